//--- all.f
+incdir+dv
hdl/crosp_pkg.sv
hdl/mem_arbiter.sv
hdl/axi_master.sv
hdl/perf_monitor.sv
hdl/mem_subsys.sv
dv/tb_mem_subsys.sv

//--- dv/tb_tests.svh
// directed tests and compares

    task automatic check_resp(input string what, input mem_resp_t exp, input mem_resp_t act,
                              input bit with_data);
        n_checks++;
        if (act.err !== exp.err || (with_data && act.rdata !== exp.rdata)) begin
            err_count++;
            $display("Fail %s %s: expected data %h err %b, actual data %h err %b",
                     test_name, what, exp.rdata, exp.err, act.rdata, act.err);
        end
    endtask

    task automatic check_count(input string what, input logic [cnt_width-1:0] exp,
                               input logic [cnt_width-1:0] act, input bit at_least);
        n_checks++;
        if (at_least ? ((act >= exp) !== 1'b1) : (act !== exp)) begin
            err_count++;
            $display("Fail %s %s: expected %s%0d, actual %0d",
                     test_name, what, at_least ? ">= " : "", exp, act);
        end
    endtask

    task automatic check_port(input string what, input port_e exp, input port_e act);
        n_checks++;
        if (act !== exp) begin
            err_count++;
            $display("Fail %s %s: expected %s, actual %s", test_name, what, exp.name(), act.name());
        end
    endtask

    function automatic mem_req_t make_req(input logic [63:0] addr, input logic [63:0] wdata,
                                          input logic [7:0] strb, input logic write);
        return '{addr: addr, wdata: wdata, strb: strb, write: write};
    endfunction

    task automatic note_request(input port_e port, input mem_req_t req);
        if (port == port_ic)
            n_fetch++;
        else if (req.write)
            n_store++;
        else
            n_load++;
    endtask

    task automatic issue_one(input port_e port, input mem_req_t req, output mem_resp_t resp);
        int waited;
        @(negedge clk);
        ic_req_vld = (port == port_ic);
        dc_req_vld = (port == port_dc);
        ic_req = req;
        dc_req = req;
        note_request(port, req);
        @(negedge clk);
        ic_req_vld = 1'b0;
        dc_req_vld = 1'b0;
        waited = 0;
        while (!(port == port_ic ? ic_resp_vld : dc_resp_vld) && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        resp = (port == port_ic) ? ic_resp : dc_resp;
        if (!(port == port_ic ? ic_resp_vld : dc_resp_vld)) begin
            err_count++;
            $display("%s: no response on the %s port within %0d cycles",
                     test_name, port.name(), timeout_cycles);
        end
    endtask

    // both ports strobe in the same cycle
    task automatic issue_pair(input mem_req_t ic_r, input mem_req_t dc_r,
                              output mem_resp_t ic_rs, output mem_resp_t dc_rs,
                              output port_e first);
        int waited;
        bit got_ic;
        bit got_dc;
        @(negedge clk);
        {ic_req_vld, dc_req_vld} = 2'b11;
        ic_req = ic_r;
        dc_req = dc_r;
        note_request(port_ic, ic_r);
        note_request(port_dc, dc_r);
        n_pairs++;
        @(negedge clk);
        {ic_req_vld, dc_req_vld} = 2'b00;
        {waited, got_ic, got_dc} = '0;
        first = port_ic;
        while (!(got_ic && got_dc) && waited < timeout_cycles) begin
            if (ic_resp_vld) begin
                ic_rs = ic_resp;
                got_ic = 1'b1;
            end
            if (dc_resp_vld) begin
                dc_rs = dc_resp;
                first = got_ic ? port_ic : port_dc;
                got_dc = 1'b1;
            end
            if (!(got_ic && got_dc)) begin
                @(negedge clk);
                waited++;
            end
        end
        if (!(got_ic && got_dc)) begin
            err_count++;
            $display("%s: paired requests did not both complete within %0d cycles",
                     test_name, timeout_cycles);
        end
    endtask

    task automatic read_counter(input perf_event_e sel, output logic [cnt_width-1:0] val,
                                output logic [cnt_width-1:0] cyc);
        int waited;
        @(negedge clk);
        csr_rd_vld = 1'b1;
        csr_rd_sel = sel;
        cyc = tb_cycles; // cycles since reset at the strobe
        @(negedge clk);
        csr_rd_vld = 1'b0;
        waited = 0;
        while (!csr_rd_ack && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        val = csr_rd_data;
        if (!csr_rd_ack || waited != 0) begin
            err_count++;
            $display("%s: read of counter %s was not acknowledged one cycle after the strobe",
                     test_name, sel.name());
        end
    endtask

    task automatic fetch_preloaded();
        mem_resp_t resp;
        begin_test("fetch_preloaded");
        issue_one(port_ic, make_req(64'h80, 64'd0, 8'd0, 1'b0), resp);
        check_resp("fetch", {fill_word(16), 1'b0}, resp, 1'b1);
        end_test();
    endtask

    task automatic partial_write();
        mem_resp_t   resp;
        logic [63:0] exp;
        begin_test("partial_write");
        issue_one(port_dc, make_req(64'h100, 64'h1122_3344_5566_7788, 8'b1010_0101, 1'b1), resp);
        check_resp("write", {64'd0, 1'b0}, resp, 1'b0);
        issue_one(port_dc, make_req(64'h100, 64'd0, 8'd0, 1'b0), resp);
        // bytes 0, 2, 5 and 7 take the new data
        exp = (fill_word(32) & ~64'hff00_ff00_00ff_00ff)
            | (64'h1122_3344_5566_7788 & 64'hff00_ff00_00ff_00ff);
        check_resp("read back", {exp, 1'b0}, resp, 1'b1);
        end_test();
    endtask

    task automatic pair_order();
        mem_resp_t ic_rs;
        mem_resp_t dc_rs;
        port_e     first;
        begin_test("pair_order");
        apply_reset();
        issue_pair(make_req(64'h18, 64'd0, 8'd0, 1'b0), make_req(64'h200, 64'd0, 8'd0, 1'b0),
                   ic_rs, dc_rs, first);
        check_resp("pair 1 ic", {fill_word(3), 1'b0}, ic_rs, 1'b1);
        check_resp("pair 1 dc", {fill_word(64), 1'b0}, dc_rs, 1'b1);
        check_port("pair 1 first", port_ic, first);
        // a lone fetch leaves ic as the last grant
        issue_one(port_ic, make_req(64'h20, 64'd0, 8'd0, 1'b0), ic_rs);
        check_resp("lone fetch", {fill_word(4), 1'b0}, ic_rs, 1'b1);
        issue_pair(make_req(64'h28, 64'd0, 8'd0, 1'b0), make_req(64'h210, 64'd0, 8'd0, 1'b0),
                   ic_rs, dc_rs, first);
        check_resp("pair 2 ic", {fill_word(5), 1'b0}, ic_rs, 1'b1);
        check_resp("pair 2 dc", {fill_word(66), 1'b0}, dc_rs, 1'b1);
        check_port("pair 2 first", port_dc, first);
        end_test();
    endtask

    task automatic error_range();
        mem_resp_t resp;
        begin_test("error_range");
        issue_one(port_dc, make_req(64'h1008, 64'd0, 8'd0, 1'b0), resp);
        check_resp("dc read", {64'd0, 1'b1}, resp, 1'b0);
        issue_one(port_ic, make_req(64'h2000, 64'd0, 8'd0, 1'b0), resp);
        check_resp("ic read", {64'd0, 1'b1}, resp, 1'b0);
        issue_one(port_dc, make_req(64'h1000, 64'hdead, 8'hff, 1'b1), resp);
        check_resp("dc write", {64'd0, 1'b1}, resp, 1'b0);
        issue_one(port_ic, make_req(64'h40, 64'd0, 8'd0, 1'b0), resp);
        check_resp("recovery", {fill_word(8), 1'b0}, resp, 1'b1);
        end_test();
    endtask

    task automatic counter_read();
        mem_resp_t            rs;
        mem_resp_t            rs2;
        port_e                first;
        logic [cnt_width-1:0] val;
        logic [cnt_width-1:0] cyc;
        begin_test("counter_read");
        apply_reset();
        check_count("debug cycles after reset", 0, dbg_cycle, 1'b0);
        issue_one(port_ic, make_req(64'h30, 64'd0, 8'd0, 1'b0), rs);
        issue_one(port_ic, make_req(64'h38, 64'd0, 8'd0, 1'b0), rs);
        issue_one(port_dc, make_req(64'h300, 64'd0, 8'd0, 1'b0), rs);
        issue_one(port_dc, make_req(64'h308, 64'h55aa, 8'hff, 1'b1), rs);
        read_counter(ev_conflict, val, cyc);
        check_count("conflicts before pairs", 0, val, 1'b0);
        issue_pair(make_req(64'h40, 64'd0, 8'd0, 1'b0), make_req(64'h310, 64'h1, 8'h0f, 1'b1),
                   rs, rs2, first);
        issue_pair(make_req(64'h48, 64'd0, 8'd0, 1'b0), make_req(64'h318, 64'd0, 8'd0, 1'b0),
                   rs, rs2, first);
        read_counter(ev_fetch, val, cyc);
        check_count("fetches", n_fetch, val, 1'b0);
        read_counter(ev_load, val, cyc);
        check_count("loads", n_load, val, 1'b0);
        read_counter(ev_store, val, cyc);
        check_count("stores", n_store, val, 1'b0);
        read_counter(ev_conflict, val, cyc);
        check_count("conflicts after pairs", 1, val, 1'b1);
        read_counter(ev_cycle, val, cyc);
        check_count("cycles", cyc, val, 1'b1);
        check_count("debug cycles", tb_cycles, dbg_cycle, 1'b0);
        end_test();
    endtask

//--- dv/tb_mem_subsys.sv
// memory subsystem testbench
`timescale 1ns/10ps
`default_nettype none

module tb_mem_subsys;
    import crosp_pkg::*;

    localparam int cnt_width = 64;
    localparam int timeout_cycles = 200;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 ic_req_vld, dc_req_vld, ic_resp_vld, dc_resp_vld;
    mem_req_t             ic_req, dc_req;
    mem_resp_t            ic_resp, dc_resp;
    axi_aw_t              aw;
    axi_w_t               w;
    axi_ar_t              ar;
    axi_b_t               b = '0;
    axi_r_t               r = '0;
    logic                 awvalid, wvalid, arvalid, bready, rready;
    logic                 awready = 1'b0;
    logic                 wready = 1'b0;
    logic                 arready = 1'b0;
    logic                 bvalid = 1'b0;
    logic                 rvalid = 1'b0;
    logic                 csr_rd_vld, csr_rd_ack;
    perf_event_e          csr_rd_sel;
    logic [cnt_width-1:0] csr_rd_data, dbg_cycle, tb_cycles;

    // slave model state
    logic [63:0]          mem [256];
    logic [16:0]          lfsr_state = 17'd70294;
    logic [1:0]           aw_dly, w_dly, ar_dly;
    logic                 aw_wait, w_wait, ar_wait, aw_have, w_have;
    axi_aw_t              aw_q;
    axi_w_t               w_q;

    // expected event counts since the last reset
    int                   n_fetch, n_load, n_store, n_pairs;
    int                   err_count, n_checks, tests_run, tests_failed, errs_at_start;
    string                test_name;

    mem_subsys #(.cnt_width(cnt_width)) mem_subsys_i (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        tb_cycles <= rst ? '0 : tb_cycles + 1'b1;
    end

    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]}; // x^17 + x^14 + 1
    endfunction

    function automatic logic [1:0] ready_delay();
        logic [1:0] d;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            d[i] = lfsr_state[0];
        end
        return d;
    endfunction

    // preload pattern, built from the full byte address
    function automatic logic [63:0] fill_word(input int idx);
        logic [10:0] a;
        a = 11'(idx << 3);
        return {16'hc0de, 5'd0, a, 21'h1f_ffff, a ^ 11'h5a5};
    endfunction

    // one 64-bit INCR beat
    function automatic bit single_beat(input logic [7:0] len, input logic [2:0] size,
                                       input logic [1:0] burst);
        return len === 8'd0 && size === 3'd3 && burst === 2'b01;
    endfunction

    task automatic pace_ready(inout logic waiting, inout logic [1:0] dly, output logic rdy);
        if (!waiting) begin
            waiting = 1'b1;
            dly = ready_delay();
        end
        rdy = 1'b0;
        if (dly == 2'd0) begin
            rdy = 1'b1;
            waiting = 1'b0;
        end else begin
            dly = dly - 1'b1;
        end
    endtask

    // AXI slave, readies held one cycle after a random delay
    always @(negedge clk) begin
        if (rst) begin
            {awready, wready, arready, bvalid, rvalid} = '0;
            {aw_wait, w_wait, ar_wait, aw_have, w_have} = '0;
        end else begin
            // beats last one cycle only
            if ((bvalid && bready !== 1'b1) || (rvalid && rready !== 1'b1)) begin
                err_count++;
                $display("%s: master was not ready for a response beat", test_name);
            end
            bvalid = 1'b0;
            rvalid = 1'b0;
            if (awready) begin
                awready = 1'b0;
                aw_have = 1'b1;
            end else if (awvalid) begin
                pace_ready(aw_wait, aw_dly, awready);
                aw_q = aw;
            end
            if (wready) begin
                wready = 1'b0;
                w_have = 1'b1;
            end else if (wvalid) begin
                pace_ready(w_wait, w_dly, wready);
                w_q = w;
            end
            if (aw_have && w_have) begin
                if (!single_beat(aw_q.len, aw_q.size, aw_q.burst) || w_q.last !== 1'b1) begin
                    err_count++;
                    $display("%s: write was not a single 64-bit beat", test_name);
                end
                if (aw_q.addr < 64'h1000) begin
                    for (int i = 0; i < 8; i++) begin
                        if (w_q.strb[i]) begin
                            mem[aw_q.addr[10:3]][8*i +: 8] = w_q.data[8*i +: 8];
                        end
                    end
                end
                b = '{id: aw_q.id, resp: (aw_q.addr < 64'h1000) ? 2'b00 : 2'b10};
                bvalid = 1'b1;
                aw_have = 1'b0;
                w_have = 1'b0;
            end
            if (arready) begin
                if (!single_beat(ar.len, ar.size, ar.burst)) begin
                    err_count++;
                    $display("%s: read was not a single 64-bit beat", test_name);
                end
                arready = 1'b0;
                rvalid = 1'b1;
                if (ar.addr >= 64'h1000) begin
                    r = '{id: ar.id, data: 64'd0, resp: 2'b10, last: 1'b1}; // SLVERR
                end else begin
                    r = '{id: ar.id, data: mem[ar.addr[10:3]], resp: 2'b00, last: 1'b1};
                end
            end else if (arvalid) begin
                pace_ready(ar_wait, ar_dly, arready);
            end
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        n_fetch = 0;
        n_load = 0;
        n_store = 0;
        n_pairs = 0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errs_at_start = err_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_count == errs_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, err_count - errs_at_start);
        end
    endtask

    `include "tb_tests.svh"

    initial begin
        rst = 1'b1;
        ic_req_vld = 1'b0;
        dc_req_vld = 1'b0;
        ic_req = '0;
        dc_req = '0;
        csr_rd_vld = 1'b0;
        csr_rd_sel = ev_cycle;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        apply_reset();
        fetch_preloaded();
        partial_write();
        pair_order();
        error_range();
        counter_read();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, n_checks, err_count);
        if (err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/mem_subsys.sv
// memory subsystem top
`timescale 1ns/10ps
`default_nettype none

module mem_subsys #(
    parameter int cnt_width = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ic_req_vld,
    input  crosp_pkg::mem_req_t    ic_req,
    output logic                   ic_resp_vld,
    output crosp_pkg::mem_resp_t   ic_resp,
    input  logic                   dc_req_vld,
    input  crosp_pkg::mem_req_t    dc_req,
    output logic                   dc_resp_vld,
    output crosp_pkg::mem_resp_t   dc_resp,
    output crosp_pkg::axi_aw_t     aw,
    output logic                   awvalid,
    input  logic                   awready,
    output crosp_pkg::axi_w_t      w,
    output logic                   wvalid,
    input  logic                   wready,
    input  crosp_pkg::axi_b_t      b,
    input  logic                   bvalid,
    output logic                   bready,
    output crosp_pkg::axi_ar_t     ar,
    output logic                   arvalid,
    input  logic                   arready,
    input  crosp_pkg::axi_r_t      r,
    input  logic                   rvalid,
    output logic                   rready,
    input  logic                   csr_rd_vld,
    input  crosp_pkg::perf_event_e csr_rd_sel,
    output logic                   csr_rd_ack,
    output logic [cnt_width-1:0]   csr_rd_data,
    output logic [cnt_width-1:0]   dbg_cycle
);
    import crosp_pkg::*;

    logic      busy;
    logic      issue_vld;
    mem_req_t  issue_req;
    port_e     issue_port;
    logic      done_vld;
    mem_resp_t done_resp;
    port_e     done_port;
    logic      ev_fetch;
    logic      ev_load;
    logic      ev_store;
    logic      ev_conflict;

    mem_arbiter arb_i (
        .clk(clk), .rst(rst),
        .ic_req_vld(ic_req_vld), .ic_req(ic_req),
        .dc_req_vld(dc_req_vld), .dc_req(dc_req),
        .busy(busy),
        .issue_vld(issue_vld), .issue_req(issue_req), .issue_port(issue_port),
        .ev_fetch(ev_fetch), .ev_load(ev_load),
        .ev_store(ev_store), .ev_conflict(ev_conflict)
    );

    axi_master axi_i (
        .clk(clk), .rst(rst),
        .issue_vld(issue_vld), .issue_req(issue_req), .issue_port(issue_port),
        .busy(busy),
        .done_vld(done_vld), .done_resp(done_resp), .done_port(done_port),
        .aw(aw), .awvalid(awvalid), .awready(awready),
        .w(w), .wvalid(wvalid), .wready(wready),
        .b(b), .bvalid(bvalid), .bready(bready),
        .ar(ar), .arvalid(arvalid), .arready(arready),
        .r(r), .rvalid(rvalid), .rready(rready)
    );

    perf_monitor #(.cnt_width(cnt_width)) perf_i (
        .clk(clk), .rst(rst),
        .ev_fetch(ev_fetch), .ev_load(ev_load),
        .ev_store(ev_store), .ev_conflict(ev_conflict),
        .csr_rd_vld(csr_rd_vld), .csr_rd_sel(csr_rd_sel),
        .csr_rd_ack(csr_rd_ack), .csr_rd_data(csr_rd_data),
        .dbg_cycle(dbg_cycle)
    );

    // steer the response back by id
    assign ic_resp_vld = done_vld && (done_port == port_ic);
    assign dc_resp_vld = done_vld && (done_port == port_dc);
    assign ic_resp     = done_resp;
    assign dc_resp     = done_resp;

endmodule

`default_nettype wire

//--- hdl/perf_monitor.sv
// event counters and counter read port
`timescale 1ns/10ps
`default_nettype none

module perf_monitor #(
    parameter int cnt_width = 64
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ev_fetch,
    input  logic                   ev_load,
    input  logic                   ev_store,
    input  logic                   ev_conflict,
    input  logic                   csr_rd_vld,
    input  crosp_pkg::perf_event_e csr_rd_sel,
    output logic                   csr_rd_ack,
    output logic [cnt_width-1:0]   csr_rd_data,
    output logic [cnt_width-1:0]   dbg_cycle
);
    import crosp_pkg::*;

    logic [num_events-1:0] ev_vec;
    logic [cnt_width-1:0]  cnt_q [num_events];
    logic                  sel_ok;

    // bit order follows perf_event_e
    assign ev_vec = {ev_conflict, ev_store, ev_load, ev_fetch, 1'b1};

    assign sel_ok    = int'(csr_rd_sel) < num_events;
    assign dbg_cycle = cnt_q[ev_cycle];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_events; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_events; i++) begin
                if (ev_vec[i]) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_rd_ack <= 1'b0;
        end else begin
            csr_rd_ack <= csr_rd_vld;
        end
    end

    // value as of the strobe cycle
    always_ff @(posedge clk) begin
        if (csr_rd_vld) begin
            csr_rd_data <= sel_ok ? cnt_q[csr_rd_sel] : '0; // unused codes read zero
        end
    end

endmodule

`default_nettype wire

//--- hdl/axi_master.sv
// single-beat AXI master
`timescale 1ns/10ps
`default_nettype none

module axi_master (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_vld,
    input  crosp_pkg::mem_req_t  issue_req,
    input  crosp_pkg::port_e     issue_port,
    output logic                 busy,
    output logic                 done_vld,
    output crosp_pkg::mem_resp_t done_resp,
    output crosp_pkg::port_e     done_port,
    output crosp_pkg::axi_aw_t   aw,
    output logic                 awvalid,
    input  logic                 awready,
    output crosp_pkg::axi_w_t    w,
    output logic                 wvalid,
    input  logic                 wready,
    input  crosp_pkg::axi_b_t    b,
    input  logic                 bvalid,
    output logic                 bready,
    output crosp_pkg::axi_ar_t   ar,
    output logic                 arvalid,
    input  logic                 arready,
    input  crosp_pkg::axi_r_t    r,
    input  logic                 rvalid,
    output logic                 rready
);
    import crosp_pkg::*;

    axi_state_e state;
    port_e      cur_port;
    logic       cur_write;
    logic       take;
    logic       r_fire;
    logic       b_fire;
    logic       aw_left;
    logic       w_left;

    assign take   = (state == st_idle) && issue_vld;
    assign r_fire = (state == st_data) && rvalid;
    assign b_fire = (state == st_resp) && bvalid;

    // aw and w handshake independently
    assign aw_left = awvalid && !awready;
    assign w_left  = wvalid && !wready;

    assign busy      = (state != st_idle) || done_vld; // high through done cycle
    assign done_port = cur_port;
    assign bready    = 1'b1;
    assign rready    = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            arvalid  <= 1'b0;
            done_vld <= 1'b0;
        end else begin
            done_vld <= 1'b0;
            case (state)
                st_idle: begin
                    if (issue_vld) begin
                        if (issue_req.write) begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                        end else begin
                            arvalid <= 1'b1;
                        end
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (cur_write) begin
                        if (awready) begin
                            awvalid <= 1'b0;
                        end
                        if (wready) begin
                            wvalid <= 1'b0;
                        end
                        if (!aw_left && !w_left) begin
                            state <= st_resp;
                        end
                    end else if (arready) begin
                        arvalid <= 1'b0;
                        state   <= st_data;
                    end
                end
                st_data: begin
                    if (rvalid) begin
                        done_vld <= 1'b1;
                        state    <= st_idle;
                    end
                end
                st_resp: begin
                    if (bvalid) begin
                        done_vld <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (take) begin
            cur_port  <= issue_port;
            cur_write <= issue_req.write;
            aw        <= '{id: id_width'(issue_port), addr: issue_req.addr,
                           len: 8'd0, size: 3'd3, burst: 2'b01};
            ar        <= '{id: id_width'(issue_port), addr: issue_req.addr,
                           len: 8'd0, size: 3'd3, burst: 2'b01};
            w         <= '{data: issue_req.wdata, strb: issue_req.strb, last: 1'b1};
        end
        if (r_fire) begin
            done_resp <= '{rdata: r.data, err: r.resp != 2'b00};
        end else if (b_fire) begin
            done_resp <= '{rdata: 64'd0, err: b.resp != 2'b00};
        end
    end

    a_aw_hold: assert property (
        @(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw)
    );

    a_w_hold: assert property (
        @(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w)
    );

    a_ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar)
    );

    // returning beat belongs to the port that was issued
    a_r_id: assert property (
        @(posedge clk) disable iff (rst)
        r_fire |-> r.id == id_width'(cur_port)
    );

    a_b_id: assert property (
        @(posedge clk) disable iff (rst)
        b_fire |-> b.id == id_width'(cur_port)
    );

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
// fetch/data request arbiter
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  logic                ic_req_vld,
    input  crosp_pkg::mem_req_t ic_req,
    input  logic                dc_req_vld,
    input  crosp_pkg::mem_req_t dc_req,
    input  logic                busy,
    output logic                issue_vld,
    output crosp_pkg::mem_req_t issue_req,
    output crosp_pkg::port_e    issue_port,
    output logic                ev_fetch,
    output logic                ev_load,
    output logic                ev_store,
    output logic                ev_conflict
);
    import crosp_pkg::*;

    logic     ic_pend;
    logic     dc_pend;
    mem_req_t ic_slot;
    mem_req_t dc_slot;
    port_e    rr_last;
    logic     issued_q;
    logic     grant_dc;

    // dc wins if alone, or if ic was granted last
    assign grant_dc = dc_pend && (!ic_pend || rr_last == port_ic);

    assign issue_vld  = !busy && !issued_q && (ic_pend || dc_pend);
    assign issue_port = grant_dc ? port_dc : port_ic;
    assign issue_req  = grant_dc ? dc_slot : ic_slot;

    assign ev_fetch    = ic_req_vld;
    assign ev_load     = dc_req_vld && !dc_req.write;
    assign ev_store    = dc_req_vld && dc_req.write;
    assign ev_conflict = ic_pend && dc_pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            ic_pend  <= 1'b0;
            dc_pend  <= 1'b0;
            rr_last  <= port_dc; // ic first after reset
            issued_q <= 1'b0;
        end else begin
            issued_q <= issue_vld;
            if (issue_vld) begin
                rr_last <= issue_port;
                if (grant_dc) begin
                    dc_pend <= 1'b0;
                end else begin
                    ic_pend <= 1'b0;
                end
            end
            if (ic_req_vld) begin
                ic_pend <= 1'b1;
            end
            if (dc_req_vld) begin
                dc_pend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ic_req_vld) begin
            ic_slot       <= ic_req;
            ic_slot.write <= 1'b0; // fetch never writes
        end
        if (dc_req_vld) begin
            dc_slot <= dc_req;
        end
    end

    // one outstanding request per port
    a_ic_single: assert property (
        @(posedge clk) disable iff (rst)
        ic_req_vld |-> !ic_pend
    );

    a_dc_single: assert property (
        @(posedge clk) disable iff (rst)
        dc_req_vld |-> !dc_pend
    );

    // master must be idle at issue and go busy right after
    a_issue_idle: assert property (
        @(posedge clk) disable iff (rst)
        issue_vld |-> !busy ##1 busy
    );

endmodule

`default_nettype wire

//--- hdl/crosp_pkg.sv
// memory subsystem shared types
`default_nettype none

package crosp_pkg;

    localparam int num_events = 5;
    localparam int id_width = 4;

    typedef enum logic {
        port_ic = 1'b0,
        port_dc = 1'b1
    } port_e;

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_data,
        st_resp
    } axi_state_e;

    // counter index, also the bit order of the event vector
    typedef enum logic [2:0] {
        ev_cycle,
        ev_fetch,
        ev_load,
        ev_store,
        ev_conflict
    } perf_event_e;

    typedef struct packed {
        logic [63:0] addr;
        logic [63:0] wdata;
        logic [7:0]  strb;
        logic        write; // always clear on fetch port
    } mem_req_t;

    typedef struct packed {
        logic [63:0] rdata;
        logic        err; // resp was not OKAY
    } mem_resp_t;

    typedef struct packed {
        logic [id_width-1:0] id;
        logic [63:0]         addr;
        logic [7:0]          len;
        logic [2:0]          size;
        logic [1:0]          burst;
    } axi_aw_t;

    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [id_width-1:0] id;
        logic [63:0]         addr;
        logic [7:0]          len;
        logic [2:0]          size;
        logic [1:0]          burst;
    } axi_ar_t;

    typedef struct packed {
        logic [id_width-1:0] id;
        logic [63:0]         data;
        logic [1:0]          resp;
        logic                last;
    } axi_r_t;

    typedef struct packed {
        logic [id_width-1:0] id;
        logic [1:0]          resp;
    } axi_b_t;

endpackage

`default_nettype wire
